/* cvt_align.sv */
`timescale 1ns/1ps
`default_nettype none

module cvt_align import cvt_pkg::*; #(
    parameter int TAG_W = 4
) (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             advance_i,
    input  logic             valid_i,
    input  logic [TAG_W-1:0] tag_i,
    input  s1_t              s1_i,
    output logic             valid_o,
    output logic [TAG_W-1:0] tag_o,
    output s2_t              s2_o
);

    localparam int ITOF_OF_EXP     = 2**EXP_BITS - 1 - EXP_BIAS;   // Infinity exponent
    localparam int ITOF_MIN_EXP    = 1 - EXP_BIAS;                 // Smallest normal
    localparam int ITOF_STICKY_EXP = -MAN_BITS - EXP_BIAS;

    logic signed [EXP_W-1:0] exp_s;
    logic [WIDE_W-1:0]       preshift;
    logic [SHAMT_W-1:0]      shamt;
    logic [EXP_W-1:0]        final_exp;
    logic                    of_before_round;
    s2_t                     s2_d;

    always_comb begin
        exp_s           = $signed(s1_i.exp);
        final_exp       = EXP_W'(exp_s + EXP_BIAS);
        preshift        = {s1_i.mant, {(WIDE_W-MAN_W){1'b0}}};
        shamt           = '0;
        of_before_round = 1'b0;
        if (s1_i.op.is_itof) begin
            if (exp_s >= ITOF_OF_EXP) begin
                final_exp       = EXP_W'(2**EXP_BITS - 2);  // Largest normal
                preshift        = '1;                       // With round and sticky set
                of_before_round = 1'b1;
            end else if (exp_s < ITOF_STICKY_EXP) begin
                final_exp = '0;
                shamt     = SHAMT_W'(MAN_BITS + 2);         // Keep sticky bits alive
            end else if (exp_s < ITOF_MIN_EXP) begin
                final_exp = '0;                             // Denormal result
                shamt     = SHAMT_W'(ITOF_MIN_EXP - exp_s);
            end
        end else begin
            // Unsigned targets reach one bit further
            if (exp_s >= (s1_i.op.is_unsigned ? INT_W : INT_W - 1)) begin
                of_before_round = 1'b1;
            end else if (exp_s < -1) begin
                shamt = SHAMT_W'(INT_W + 1);                // Everything into sticky
            end else begin
                shamt = SHAMT_W'(INT_W - 1 - exp_s);
            end
        end
    end

    always_comb begin
        s2_d.op              = s1_i.op;
        s2_d.cls             = s1_i.cls;
        s2_d.sign            = s1_i.sign;
        s2_d.mant_zero       = s1_i.mant_zero;
        s2_d.of_before_round = of_before_round;
        s2_d.exp             = final_exp;
        s2_d.mant            = preshift >> shamt;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else if (advance_i) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            tag_o <= tag_i;
            s2_o  <= s2_d;
        end
    end

endmodule

`default_nettype wire

/* cvt_finalize.sv */
`timescale 1ns/1ps
`default_nettype none

module cvt_finalize import cvt_pkg::*; #(
    parameter int TAG_W = 4
) (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             ready_i,
    input  logic             valid_i,
    input  logic [TAG_W-1:0] tag_i,
    input  s3_t              s3_i,
    output logic             advance_o,
    output logic             valid_o,
    output logic [TAG_W-1:0] tag_o,
    output logic [31:0]      result_o,
    output fflags_t          fflags_o
);

    logic          stall;
    logic [EXP_BITS-1:0] res_exp;
    logic          uf_after_round;
    logic          of_after_round;
    logic [31:0]   fmt_result;
    logic [31:0]   int_res;
    logic          int_res_zero;
    logic          int_special;
    logic [31:0]   int_sat;
    logic [31:0]   result_d;
    fflags_t       flags_d;

    assign res_exp        = s3_i.rounded_abs[EXP_BITS+MAN_BITS-1:MAN_BITS];
    assign uf_after_round = (res_exp == '0);     // Denormal after rounding
    assign of_after_round = (res_exp == '1);     // Rounded up into infinity

    assign fmt_result = s3_i.mant_zero ? {s3_i.sign, 31'b0}
                                       : {s3_i.rounded_sign, s3_i.rounded_abs[30:0]};

    assign int_res      = s3_i.rounded_sign ? (-s3_i.rounded_abs) : s3_i.rounded_abs;
    assign int_res_zero = (int_res == '0);

    // NaN, infinity, out of range, or a negative value into unsigned
    assign int_special = s3_i.cls.is_nan | s3_i.cls.is_inf | s3_i.of_before_round
                       | (s3_i.sign & s3_i.op.is_unsigned & ~int_res_zero);

    // NaN saturates toward the positive end
    always_comb begin
        if (s3_i.sign && !s3_i.cls.is_nan) begin
            int_sat = {~s3_i.op.is_unsigned, 31'b0};
        end else begin
            int_sat = {s3_i.op.is_unsigned, {31{1'b1}}};
        end
    end

    always_comb begin
        flags_d = '0;
        if (s3_i.op.is_itof) begin
            result_d   = fmt_result;
            flags_d.nv = s3_i.of_before_round | of_after_round;
            flags_d.uf = uf_after_round & s3_i.fp_sticky_any;
            flags_d.nx = s3_i.fp_sticky_any;
        end else if (int_special) begin
            result_d   = int_sat;
            flags_d.nv = 1'b1;                   // Signaling NaN lands here too
        end else begin
            result_d   = int_res;
            flags_d.nx = s3_i.int_sticky_any;
        end
    end

    // Whole pipe freezes while a result waits downstream
    assign stall     = valid_o & ~ready_i;
    assign advance_o = ~stall;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else if (advance_o) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_o) begin
            tag_o    <= tag_i;
            result_o <= result_d;
            fflags_o <= flags_d;
        end
    end

endmodule

`default_nettype wire

/* cvt_normalize.sv */
`timescale 1ns/1ps
`default_nettype none

module cvt_normalize import cvt_pkg::*; #(
    parameter int TAG_W = 4
) (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             advance_i,
    input  logic             valid_i,
    input  logic [TAG_W-1:0] tag_i,
    input  s0_t              s0_i,
    output logic             valid_o,
    output logic [TAG_W-1:0] tag_o,
    output s1_t              s1_o
);

    // Hidden bit of a float mantissa sits this far below the MSB
    localparam int FMT_SHIFT_COMP = MAN_W - 1 - MAN_BITS;

    logic [LZC_W-1:0] lz_cnt;
    s1_t              s1_d;

    // Last set bit scanning upward is the leading one
    always_comb begin
        lz_cnt = '0;
        for (int i = 0; i < MAN_W; i++) begin
            if (s0_i.mant[i]) lz_cnt = LZC_W'(MAN_W - 1 - i);
        end
    end

    always_comb begin
        s1_d.op        = s0_i.op;
        s1_d.cls       = s0_i.cls;
        s1_d.sign      = s0_i.sign;
        s1_d.mant_zero = ~|s0_i.mant;
        s1_d.mant      = s0_i.mant << lz_cnt;
        if (s0_i.op.is_itof) begin
            s1_d.exp = EXP_W'(MAN_W - 1) - {{(EXP_W-LZC_W){1'b0}}, lz_cnt};
        end else begin
            s1_d.exp = s0_i.exp + EXP_W'(FMT_SHIFT_COMP - EXP_BIAS)
                     - {{(EXP_W-LZC_W){1'b0}}, lz_cnt};
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else if (advance_i) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            tag_o <= tag_i;
            s1_o  <= s1_d;
        end
    end

endmodule

`default_nettype wire

/* cvt_pkg.sv */
`default_nettype none

package cvt_pkg;

    localparam int MAN_BITS = 23;
    localparam int EXP_BITS = 8;
    localparam int EXP_BIAS = 127;
    localparam int INT_W    = 32;          // Integer operand and result width
    localparam int MAN_W    = 32;          // Holds a whole integer or 1.mantissa
    localparam int EXP_W    = 9;           // Signed, covers smallest subnormal
    localparam int LZC_W    = 5;
    localparam int SHAMT_W  = 6;
    localparam int WIDE_W   = 2 * MAN_W + 1;

    // RISC-V frm encodings
    typedef enum logic [2:0] {
        RNE = 3'd0,
        RTZ = 3'd1,
        RDN = 3'd2,
        RUP = 3'd3,
        RMM = 3'd4
    } rnd_mode_e;

    typedef struct packed {
        logic is_normal;
        logic is_zero;
        logic is_subnormal;
        logic is_inf;
        logic is_nan;
        logic is_quiet;
        logic is_signaling;
    } fp_class_t;

    typedef struct packed {
        logic      is_itof;                // Else float to integer
        logic      is_unsigned;
        rnd_mode_e rnd;
    } cvt_op_t;

    typedef struct packed {
        logic nv;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    // Unpacked operand
    typedef struct packed {
        cvt_op_t            op;
        fp_class_t          cls;
        logic               sign;
        logic [EXP_W-1:0]   exp;           // Biased, subnormals lifted by one
        logic [MAN_W-1:0]   mant;
    } s0_t;

    typedef struct packed {
        cvt_op_t            op;
        fp_class_t          cls;
        logic               sign;
        logic               mant_zero;
        logic [EXP_W-1:0]   exp;           // Unbiased true exponent
        logic [MAN_W-1:0]   mant;          // MSB set unless mant_zero
    } s1_t;

    typedef struct packed {
        cvt_op_t            op;
        fp_class_t          cls;
        logic               sign;
        logic               mant_zero;
        logic               of_before_round;
        logic [EXP_W-1:0]   exp;
        logic [WIDE_W-1:0]  mant;
    } s2_t;

    typedef struct packed {
        cvt_op_t            op;
        fp_class_t          cls;
        logic               sign;
        logic               mant_zero;
        logic               of_before_round;
        logic               rounded_sign;
        logic [INT_W-1:0]   rounded_abs;
        logic               fp_sticky_any;  // Round or sticky, float position
        logic               int_sticky_any; // Round or sticky, integer position
    } s3_t;

endpackage

`default_nettype wire

/* cvt_round.sv */
`timescale 1ns/1ps
`default_nettype none

module cvt_round import cvt_pkg::*; #(
    parameter int TAG_W = 4
) (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             advance_i,
    input  logic             valid_i,
    input  logic [TAG_W-1:0] tag_i,
    input  s2_t              s2_i,
    output logic             valid_o,
    output logic [TAG_W-1:0] tag_o,
    output s3_t              s3_o
);

    localparam int FP_STICKY_N  = 2 * MAN_W - MAN_BITS - 1;  // Below mantissa and round bit
    localparam int INT_STICKY_N = 2 * MAN_W - INT_W;         // Below integer and round bit

    logic [MAN_BITS-1:0] final_mant;
    logic [INT_W-1:0]    final_int;
    logic [1:0]          fp_rs;
    logic [1:0]          int_rs;
    logic [1:0]          rs;
    logic [INT_W-1:0]    pre_abs;
    logic                round_up;
    s3_t                 s3_d;

    // Hidden bit at 2*MAN_W is dropped for float results
    assign final_mant = s2_i.mant[2*MAN_W-1 -: MAN_BITS];
    assign fp_rs[1]   = s2_i.mant[2*MAN_W-1-MAN_BITS];
    assign fp_rs[0]   = |s2_i.mant[FP_STICKY_N-1:0];
    assign final_int  = s2_i.mant[2*MAN_W -: INT_W];
    assign int_rs[1]  = s2_i.mant[2*MAN_W-INT_W];
    assign int_rs[0]  = |s2_i.mant[INT_STICKY_N-1:0];

    assign rs      = s2_i.op.is_itof ? fp_rs : int_rs;
    assign pre_abs = s2_i.op.is_itof ? {1'b0, s2_i.exp[EXP_BITS-1:0], final_mant} : final_int;

    always_comb begin
        case (s2_i.op.rnd)
            RNE:     round_up = rs[1] & (rs[0] | pre_abs[0]);  // Tie goes to even
            RTZ:     round_up = 1'b0;
            RDN:     round_up = (|rs) & s2_i.sign;
            RUP:     round_up = (|rs) & ~s2_i.sign;
            RMM:     round_up = rs[1];
            default: round_up = 1'b0;
        endcase
    end

    // Carry out of the mantissa bumps the exponent by itself
    always_comb begin
        s3_d.op              = s2_i.op;
        s3_d.cls             = s2_i.cls;
        s3_d.sign            = s2_i.sign;
        s3_d.mant_zero       = s2_i.mant_zero;
        s3_d.of_before_round = s2_i.of_before_round;
        s3_d.rounded_sign    = s2_i.sign;
        s3_d.rounded_abs     = pre_abs + {{(INT_W-1){1'b0}}, round_up};
        s3_d.fp_sticky_any   = |fp_rs;
        s3_d.int_sticky_any  = |int_rs;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else if (advance_i) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            tag_o <= tag_i;
            s3_o  <= s3_d;
        end
    end

endmodule

`default_nettype wire

/* cvt_unpack.sv */
`timescale 1ns/1ps
`default_nettype none

module cvt_unpack import cvt_pkg::*; #(
    parameter int TAG_W = 4
) (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             advance_i,
    input  logic             valid_i,
    input  logic [TAG_W-1:0] tag_i,
    input  cvt_op_t          op_i,
    input  logic [31:0]      data_i,
    output logic             valid_o,
    output logic [TAG_W-1:0] tag_o,
    output s0_t              s0_o
);

    logic             exp_ones;
    logic             exp_zero;
    logic             man_zero;
    logic             int_sign;
    logic [MAN_W-1:0] int_mant;
    logic [MAN_W-1:0] fmt_mant;
    fp_class_t        cls;
    s0_t              s0_d;

    assign exp_ones = &data_i[MAN_BITS+EXP_BITS-1:MAN_BITS];
    assign exp_zero = ~|data_i[MAN_BITS+EXP_BITS-1:MAN_BITS];
    assign man_zero = ~|data_i[MAN_BITS-1:0];

    // Classify operand as binary32
    assign cls.is_normal    = ~exp_zero & ~exp_ones;
    assign cls.is_zero      = exp_zero & man_zero;
    assign cls.is_subnormal = exp_zero & ~man_zero;
    assign cls.is_inf       = exp_ones & man_zero;
    assign cls.is_nan       = exp_ones & ~man_zero;
    assign cls.is_quiet     = cls.is_nan & data_i[MAN_BITS-1];
    assign cls.is_signaling = cls.is_nan & ~data_i[MAN_BITS-1];

    assign int_sign = data_i[31] & ~op_i.is_unsigned;
    assign int_mant = int_sign ? (-data_i) : data_i;   // Two's complement magnitude
    assign fmt_mant = {{(MAN_W-MAN_BITS-1){1'b0}}, cls.is_normal, data_i[MAN_BITS-1:0]};

    always_comb begin
        s0_d.op   = op_i;
        s0_d.cls  = cls;
        s0_d.sign = op_i.is_itof ? int_sign : data_i[31];
        // Subnormals share the exponent of the smallest normal
        s0_d.exp  = {1'b0, data_i[MAN_BITS+EXP_BITS-1:MAN_BITS]}
                  + {{(EXP_W-1){1'b0}}, cls.is_subnormal};
        s0_d.mant = op_i.is_itof ? int_mant : fmt_mant;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else if (advance_i) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            tag_o <= tag_i;
            s0_o  <= s0_d;
        end
    end

endmodule

`default_nettype wire

/* fp_cvt.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_cvt import cvt_pkg::*; #(
    parameter int TAG_W = 4
) (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             valid_i,
    input  logic [TAG_W-1:0] tag_i,
    input  cvt_op_t          op_i,
    input  logic [31:0]      data_i,
    input  logic             ready_i,
    output logic             ready_o,           // Also the global advance
    output logic             valid_o,
    output logic [TAG_W-1:0] tag_o,
    output logic [31:0]      result_o,
    output fflags_t          fflags_o
);

    logic             valid_s0, valid_s1, valid_s2, valid_s3;
    logic [TAG_W-1:0] tag_s0, tag_s1, tag_s2, tag_s3;
    s0_t              s0;
    s1_t              s1;
    s2_t              s2;
    s3_t              s3;

    cvt_unpack #(.TAG_W(TAG_W)) u_unpack (
        .clk(clk), .rst_i(rst_i), .advance_i(ready_o),
        .valid_i(valid_i), .tag_i(tag_i), .op_i(op_i), .data_i(data_i),
        .valid_o(valid_s0), .tag_o(tag_s0), .s0_o(s0)
    );

    cvt_normalize #(.TAG_W(TAG_W)) u_normalize (
        .clk(clk), .rst_i(rst_i), .advance_i(ready_o),
        .valid_i(valid_s0), .tag_i(tag_s0), .s0_i(s0),
        .valid_o(valid_s1), .tag_o(tag_s1), .s1_o(s1)
    );

    cvt_align #(.TAG_W(TAG_W)) u_align (
        .clk(clk), .rst_i(rst_i), .advance_i(ready_o),
        .valid_i(valid_s1), .tag_i(tag_s1), .s1_i(s1),
        .valid_o(valid_s2), .tag_o(tag_s2), .s2_o(s2)
    );

    cvt_round #(.TAG_W(TAG_W)) u_round (
        .clk(clk), .rst_i(rst_i), .advance_i(ready_o),
        .valid_i(valid_s2), .tag_i(tag_s2), .s2_i(s2),
        .valid_o(valid_s3), .tag_o(tag_s3), .s3_o(s3)
    );

    cvt_finalize #(.TAG_W(TAG_W)) u_finalize (
        .clk(clk), .rst_i(rst_i), .ready_i(ready_i),
        .valid_i(valid_s3), .tag_i(tag_s3), .s3_i(s3),
        .advance_o(ready_o), .valid_o(valid_o), .tag_o(tag_o),
        .result_o(result_o), .fflags_o(fflags_o)
    );

endmodule

`default_nettype wire

/* src.f */
cvt_pkg.sv
cvt_unpack.sv
cvt_normalize.sv
cvt_align.sv
cvt_round.sv
cvt_finalize.sv
fp_cvt.sv
tb_clkgen.sv
tb_fp_cvt_assert.sv
tb_fp_cvt.sv

/* tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // Synchronous reset, released on a rising edge
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

`default_nettype wire

/* tb_fp_cvt.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fp_cvt import cvt_pkg::*; ();

    localparam int          TAG_W         = 4;
    localparam int          STREAM_N      = 60;
    localparam int          TOTAL_OPS     = 4 + 6 + 7 + 5 + 1 + STREAM_N;  // Sum over all tests
    localparam int          CYCLES_PER_OP = 200;
    localparam logic [31:0] LFSR_SEED     = 32'd94126;
    localparam logic [31:0] LFSR_TAPS     = 32'h80200003;

    localparam fflags_t NO_FLAGS = 4'b0000;    // Order nv, of, uf, nx
    localparam fflags_t NV_ONLY  = 4'b1000;
    localparam fflags_t NX_ONLY  = 4'b0001;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [31:0]      result;
        fflags_t          flags;
        int               cycle;                // Edge count when consumed
    } out_rec_t;

    logic             clk;
    logic             rst;
    logic             valid_in;
    logic [TAG_W-1:0] tag_in;
    cvt_op_t          op_in;
    logic [31:0]      data_in;
    logic             ready_in;
    logic             ready_out;
    logic             valid_out;
    logic [TAG_W-1:0] tag_out;
    logic [31:0]      result_out;
    fflags_t          flags_out;

    out_rec_t         out_q[$];
    int               cycle;
    int               err_cnt;
    int               tests_run;
    int               tests_failed;
    logic [31:0]      lfsr_state;
    logic [TAG_W-1:0] next_tag;
    logic             stream_done;

    tb_clkgen #(.PERIOD_NS(4.0), .RESET_CYCLES(5)) u_clkgen (.clk_o(clk), .rst_o(rst));

    fp_cvt #(.TAG_W(TAG_W)) DUT (
        .clk(clk), .rst_i(rst), .valid_i(valid_in), .tag_i(tag_in), .op_i(op_in),
        .data_i(data_in), .ready_i(ready_in), .ready_o(ready_out), .valid_o(valid_out),
        .tag_o(tag_out), .result_o(result_out), .fflags_o(flags_out)
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Record every output taken on this edge
    always @(posedge clk) begin
        if (!rst && valid_out && ready_in) begin
            out_q.push_back(out_rec_t'{tag: tag_out, result: result_out,
                                       flags: flags_out, cycle: cycle});
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {1'b0, state[31:1]} ^ (state[0] ? LFSR_TAPS : 32'h0);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    // Exact binary32 of a signed integer below 2^24 in magnitude
    function automatic logic [31:0] exact_float(input logic [31:0] value);
        logic        neg;
        logic [31:0] mag;
        int          msb;
        neg = value[31];
        mag = neg ? -value : value;
        msb = 0;
        if (mag == 0) return 32'h0;
        for (int i = 0; i < 32; i++) begin
            if (mag[i]) msb = i;
        end
        return {neg, 8'(127 + msb), 23'(mag << (23 - msb))};  // Hidden bit drops off
    endfunction

    function automatic cvt_op_t make_op(input logic itof, input logic uns, input rnd_mode_e rnd);
        cvt_op_t op;
        op.is_itof     = itof;
        op.is_unsigned = uns;
        op.rnd         = rnd;
        return op;
    endfunction

    task automatic check_result(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s result %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_flags(input fflags_t got, input fflags_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s flags %b, expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_tag(input logic [TAG_W-1:0] got, input logic [TAG_W-1:0] exp,
                             input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s tag %0d, expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("CHECK FAILED at %0t: %s latency %0d, expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // Called on a rising edge; returns on the edge that accepts the operation
    task automatic send_op(input cvt_op_t op, input logic [31:0] data, output int accepted);
        valid_in <= 1'b1;
        tag_in   <= next_tag;
        op_in    <= op;
        data_in  <= data;
        next_tag = next_tag + 1'b1;
        @(posedge clk);
        while (!ready_out) @(posedge clk);
        accepted = cycle;
    endtask

    task automatic wait_output(output out_rec_t rec);
        while (out_q.size() == 0) @(posedge clk);
        rec = out_q.pop_front();
    endtask

    task automatic convert_one(input cvt_op_t op, input logic [31:0] data,
                               input logic [31:0] exp_res, input fflags_t exp_flags,
                               input string what, output int latency);
        out_rec_t         rec;
        int               accepted;
        logic [TAG_W-1:0] tag;
        tag = next_tag;
        send_op(op, data, accepted);
        valid_in <= 1'b0;
        wait_output(rec);
        check_tag(rec.tag, tag, what);
        check_result(rec.result, exp_res, what);
        check_flags(rec.flags, exp_flags, what);
        latency = rec.cycle - accepted;
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (err_cnt == err_before) begin
            $display("%-26s ok", name);
        end else begin
            tests_failed++;
            $display("%-26s failed, %0d errors", name, err_cnt - err_before);
        end
    endtask

    task automatic test_exact_itof();
        int e0;
        int lat;
        e0 = err_cnt;
        convert_one(make_op(1, 0, RNE), 32'd0, 32'h0000_0000, NO_FLAGS, "itof 0", lat);
        convert_one(make_op(1, 0, RNE), 32'd1, 32'h3F80_0000, NO_FLAGS, "itof 1", lat);
        convert_one(make_op(1, 0, RNE), 32'hFFFF_FFFE, 32'hC000_0000, NO_FLAGS, "itof -2", lat);
        convert_one(make_op(1, 1, RNE), 32'h8000_0000, 32'h4F00_0000, NO_FLAGS, "itof 2^31", lat);
        finish_test("exact itof", e0);
    endtask

    task automatic test_inexact_itof();
        int e0;
        int lat;
        e0 = err_cnt;
        convert_one(make_op(1, 0, RNE), 32'd16777217, 32'h4B80_0000, NX_ONLY, "2^24+1 rne", lat);
        convert_one(make_op(1, 0, RTZ), 32'd16777217, 32'h4B80_0000, NX_ONLY, "2^24+1 rtz", lat);
        convert_one(make_op(1, 0, RDN), 32'd16777217, 32'h4B80_0000, NX_ONLY, "2^24+1 rdn", lat);
        convert_one(make_op(1, 0, RUP), 32'd16777217, 32'h4B80_0001, NX_ONLY, "2^24+1 rup", lat);
        convert_one(make_op(1, 1, RTZ), 32'hFFFF_FFFF, 32'h4F7F_FFFF, NX_ONLY, "umax rtz", lat);
        convert_one(make_op(1, 1, RNE), 32'hFFFF_FFFF, 32'h4F80_0000, NX_ONLY, "umax rne", lat);
        finish_test("inexact itof", e0);
    endtask

    task automatic test_regular_ftoi();
        int e0;
        int lat;
        e0 = err_cnt;
        convert_one(make_op(0, 0, RNE), 32'h4020_0000, 32'd2, NX_ONLY, "2.5 rne", lat);
        convert_one(make_op(0, 0, RTZ), 32'h4020_0000, 32'd2, NX_ONLY, "2.5 rtz", lat);
        convert_one(make_op(0, 0, RUP), 32'h4020_0000, 32'd3, NX_ONLY, "2.5 rup", lat);
        convert_one(make_op(0, 0, RMM), 32'h4020_0000, 32'd3, NX_ONLY, "2.5 rmm", lat);
        convert_one(make_op(0, 0, RDN), 32'hBFC0_0000, 32'hFFFF_FFFE, NX_ONLY, "-1.5 rdn", lat);
        convert_one(make_op(0, 0, RTZ), 32'hBFC0_0000, 32'hFFFF_FFFF, NX_ONLY, "-1.5 rtz", lat);
        convert_one(make_op(0, 0, RNE), 32'h4080_0000, 32'd4, NO_FLAGS, "4.0", lat);
        finish_test("regular ftoi", e0);
    endtask

    task automatic test_special_ftoi();
        int e0;
        int lat;
        e0 = err_cnt;
        convert_one(make_op(0, 0, RNE), 32'h7FC0_0000, 32'h7FFF_FFFF, NV_ONLY, "qnan signed", lat);
        convert_one(make_op(0, 1, RNE), 32'h7F80_0001, 32'hFFFF_FFFF, NV_ONLY, "snan unsigned", lat);
        convert_one(make_op(0, 0, RNE), 32'hFF80_0000, 32'h8000_0000, NV_ONLY, "-inf signed", lat);
        convert_one(make_op(0, 0, RNE), 32'h4F32_D05E, 32'h7FFF_FFFF, NV_ONLY, "3.0e9 signed", lat);
        convert_one(make_op(0, 1, RNE), 32'hC040_0000, 32'h0000_0000, NV_ONLY, "-3.0 unsigned", lat);
        finish_test("special ftoi", e0);
    endtask

    // Consumed on the fifth edge after the accepting one, five registers deep
    task automatic test_latency();
        int e0;
        int lat;
        e0 = err_cnt;
        convert_one(make_op(1, 0, RNE), 32'd7, 32'h40E0_0000, NO_FLAGS, "itof 7", lat);
        check_latency(lat, 5, "single op");
        finish_test("latency", e0);
    endtask

    task automatic test_stream();
        logic [31:0]      vals[STREAM_N];
        logic [31:0]      mag;
        logic [31:0]      sgn;
        out_rec_t         rec;
        cvt_op_t          op;
        int               e0;
        int               acc;
        logic [TAG_W-1:0] first_tag;
        e0        = err_cnt;
        op        = make_op(1, 0, RNE);
        first_tag = next_tag;
        for (int i = 0; i < STREAM_N; i++) begin
            rand_bits(24, mag);
            rand_bits(1, sgn);
            vals[i] = sgn[0] ? -mag : mag;
        end
        stream_done = 1'b0;
        fork
            begin
                for (int i = 0; i < STREAM_N; i++) begin
                    send_op(op, vals[i], acc);
                end
                valid_in <= 1'b0;
            end
            begin
                while (out_q.size() < STREAM_N) @(posedge clk);
                stream_done = 1'b1;
            end
            begin
                logic [31:0] rdy;
                while (!stream_done) begin
                    @(posedge clk);
                    rand_bits(1, rdy);
                    ready_in <= rdy[0];
                end
                ready_in <= 1'b1;
            end
        join
        for (int i = 0; i < STREAM_N; i++) begin
            rec = out_q.pop_front();
            check_tag(rec.tag, first_tag + TAG_W'(i), $sformatf("stream %0d", i));
            check_result(rec.result, exact_float(vals[i]), $sformatf("stream %0d", i));
            check_flags(rec.flags, NO_FLAGS, $sformatf("stream %0d", i));
        end
        finish_test("stream with back-pressure", e0);
    endtask

    initial begin
        valid_in     = 1'b0;
        tag_in       = '0;
        op_in        = '0;
        data_in      = '0;
        ready_in     = 1'b1;
        lfsr_state   = LFSR_SEED;
        next_tag     = '0;
        stream_done  = 1'b0;
        err_cnt      = 0;
        tests_run    = 0;
        tests_failed = 0;
        @(posedge clk);
        while (rst !== 1'b0) @(posedge clk);

        test_exact_itof();
        test_inexact_itof();
        test_regular_ftoi();
        test_special_ftoi();
        test_latency();
        test_stream();
        repeat (2) @(posedge clk);

        $display("tests %0d, failed %0d, check errors %0d, assertion errors %0d",
                 tests_run, tests_failed, err_cnt, DUT.u_assert.fail_cnt);
        if (err_cnt == 0 && tests_failed == 0 && DUT.u_assert.fail_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TOTAL_OPS * CYCLES_PER_OP) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles",
                 TOTAL_OPS * CYCLES_PER_OP);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_fp_cvt_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fp_cvt_assert import cvt_pkg::*; #(
    parameter int TAG_W = 4
) (
    input logic             clk,
    input logic             rst_i,
    input logic             ready_in_i,     // DUT ready_i
    input logic             ready_out_i,    // DUT ready_o
    input logic             valid_out_i,
    input logic [TAG_W-1:0] tag_out_i,
    input logic [31:0]      result_out_i,
    input fflags_t          fflags_out_i
);

    int unsigned fail_cnt = 0;              // Failed assertions so far

    a_reset_valid: assert property (@(posedge clk) rst_i |=> !valid_out_i)
        else begin
            $error("valid_o high in the cycle after reset");
            fail_cnt++;
        end

    // Upstream ready is the global advance
    a_ready_stall: assert property (@(posedge clk) disable iff (rst_i)
        ready_out_i == !(valid_out_i && !ready_in_i))
        else begin
            $error("ready_o does not match the stall condition");
            fail_cnt++;
        end

    a_hold_output: assert property (@(posedge clk) disable iff (rst_i)
        (valid_out_i && !ready_in_i) |=> (valid_out_i && $stable(result_out_i)
                                          && $stable(tag_out_i) && $stable(fflags_out_i)))
        else begin
            $error("output changed while stalled");
            fail_cnt++;
        end

endmodule

bind fp_cvt tb_fp_cvt_assert #(.TAG_W(TAG_W)) u_assert (
    .clk(clk), .rst_i(rst_i), .ready_in_i(ready_i), .ready_out_i(ready_o),
    .valid_out_i(valid_o), .tag_out_i(tag_o), .result_out_i(result_o),
    .fflags_out_i(fflags_o)
);

`default_nettype wire
